//--- include/control_config.svh
`ifndef CONTROL_CONFIG_SVH
`define CONTROL_CONFIG_SVH

`define XLEN 32

// RV32 major opcodes
`define OP_R      7'b0110011
`define OP_I      7'b0010011
`define OP_LOAD   7'b0000011
`define OP_JALR   7'b1100111
`define OP_STORE  7'b0100011
`define OP_BRANCH 7'b1100011
`define OP_AUIPC  7'b0010111
`define OP_LUI    7'b0110111
`define OP_JAL    7'b1101111
`define OP_SYSTEM 7'b1110011

// Integer and M-extension func3
`define F3_ADD  3'b000
`define F3_SLL  3'b001
`define F3_SLT  3'b010
`define F3_SLTU 3'b011
`define F3_XOR  3'b100
`define F3_SR   3'b101
`define F3_OR   3'b110
`define F3_AND  3'b111

`define F3_LB  3'b000
`define F3_LH  3'b001
`define F3_LW  3'b010
`define F3_LBU 3'b100
`define F3_LHU 3'b101

`define F3_SB 3'b000
`define F3_SH 3'b001
`define F3_SW 3'b010

`define F3_BEQ  3'b000
`define F3_BNE  3'b001
`define F3_BLT  3'b100
`define F3_BGE  3'b101
`define F3_BLTU 3'b110
`define F3_BGEU 3'b111

`define F3_PRIV   3'b000 // MRET and WFI live here
`define F3_CSRRW  3'b001
`define F3_CSRRS  3'b010
`define F3_CSRRC  3'b011
`define F3_CSRRWI 3'b101
`define F3_CSRRSI 3'b110
`define F3_CSRRCI 3'b111

`define ALU_ADD    5'd0
`define ALU_SUB    5'd1
`define ALU_SLL    5'd2
`define ALU_SLT    5'd3
`define ALU_SLTU   5'd4
`define ALU_XOR    5'd5
`define ALU_SRL    5'd6
`define ALU_SRA    5'd7
`define ALU_OR     5'd8
`define ALU_AND    5'd9
`define ALU_MUL    5'd10
`define ALU_MULH   5'd11
`define ALU_MULHSU 5'd12
`define ALU_MULHU  5'd13
`define ALU_BEQ    5'd14
`define ALU_BNE    5'd15
`define ALU_BLT    5'd16
`define ALU_BGE    5'd17
`define ALU_BLTU   5'd18
`define ALU_BGEU   5'd19
`define ALU_JAL    5'd20

`define STRB_BYTE  4'b0001
`define STRB_HWORD 4'b0011
`define STRB_WORD  4'b1111

`define F12_MRET 12'h302
`define F12_WFI  12'h105

`endif

//--- src/control_pkg.sv
`default_nettype none

`include "control_config.svh"

package control_pkg;

    // Register-type view of the word
    typedef struct packed {
        logic [6:0] func7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] func3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rView_s;

    // SYSTEM view where the upper bits form one code
    typedef struct packed {
        logic [11:0] funct12;
        logic [4:0]  rs1;
        logic [2:0]  func3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } sysView_s;

    typedef union packed {
        rView_s   r;
        sysView_s sys;
    } instrWord_u;

    typedef enum logic [3:0] {
        CLASS_R, CLASS_I, CLASS_LOAD, CLASS_JALR, CLASS_STORE, CLASS_BRANCH,
        CLASS_AUIPC, CLASS_LUI, CLASS_JAL, CLASS_SYSTEM, CLASS_ILLEGAL
    } instrClass_e;

    typedef enum logic [4:0] {
        ALU_ADD = `ALU_ADD, ALU_SUB = `ALU_SUB, ALU_SLL = `ALU_SLL,
        ALU_SLT = `ALU_SLT, ALU_SLTU = `ALU_SLTU, ALU_XOR = `ALU_XOR,
        ALU_SRL = `ALU_SRL, ALU_SRA = `ALU_SRA, ALU_OR = `ALU_OR,
        ALU_AND = `ALU_AND, ALU_MUL = `ALU_MUL, ALU_MULH = `ALU_MULH,
        ALU_MULHSU = `ALU_MULHSU, ALU_MULHU = `ALU_MULHU, ALU_BEQ = `ALU_BEQ,
        ALU_BNE = `ALU_BNE, ALU_BLT = `ALU_BLT, ALU_BGE = `ALU_BGE,
        ALU_BLTU = `ALU_BLTU, ALU_BGEU = `ALU_BGEU, ALU_JAL = `ALU_JAL
    } aluOp_e;

    typedef enum logic [2:0] {
        IMM_NONE, IMM_I, IMM_ISHIFT, IMM_S, IMM_B, IMM_U, IMM_J, IMM_CSR
    } immOp_e;

    typedef enum logic [2:0] {
        RD_ALU, RD_PC4, RD_PCIMM, RD_IMM, RD_CSR // RD_ALU also covers MEM
    } rdSrc_e;

    typedef enum logic [2:0] {LD_WORD, LD_BYTE, LD_HALF, LD_HALFU, LD_BYTEU} loadCon_e;

    typedef enum logic [1:0] {ST_BYTE, ST_HALF, ST_WORD} storeCon_e;

    typedef enum logic [1:0] {CSR_DATA, CSR_OR, CSR_ANDN} csrAluOp_e;

    typedef struct packed {
        aluOp_e aluOp;
        logic   aluSrc;  // 1 selects immediate
        immOp_e immOp;
    } exCtrl_s;

    typedef struct packed {
        logic [3:0] webN;  // Active-low byte write enables
        logic       memRead;
        loadCon_e   loadCon;
        storeCon_e  storeCon;
    } memCtrl_s;

    typedef struct packed {
        logic   regWrite;
        logic   memtoReg;  // 0 picks memory data
        rdSrc_e rdSrc;
    } wbCtrl_s;

    typedef struct packed {
        logic jump;
        logic branch;
        logic pcSel;  // 1 is rs1 + imm
    } flowCtrl_s;

    typedef struct packed {
        logic      wfi;
        logic      csrReturn;
        logic      csrWrite;
        logic      csrAluSrc;  // 1 uses zimm
        csrAluOp_e csrAluOp;
    } csrCtrl_s;

endpackage

`default_nettype wire

//--- src/mainDecoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "control_config.svh"

module mainDecoder (
    input  var logic [6:0]               opcode,
    input  var logic                     csrAccess,
    output control_pkg::instrClass_e     instrClass,
    output control_pkg::wbCtrl_s         wbCtrl,
    output control_pkg::flowCtrl_s       flowCtrl
);
    import control_pkg::*;

    always_comb begin
        case (opcode)
            `OP_R:      instrClass = CLASS_R;
            `OP_I:      instrClass = CLASS_I;
            `OP_LOAD:   instrClass = CLASS_LOAD;
            `OP_JALR:   instrClass = CLASS_JALR;
            `OP_STORE:  instrClass = CLASS_STORE;
            `OP_BRANCH: instrClass = CLASS_BRANCH;
            `OP_AUIPC:  instrClass = CLASS_AUIPC;
            `OP_LUI:    instrClass = CLASS_LUI;
            `OP_JAL:    instrClass = CLASS_JAL;
            `OP_SYSTEM: instrClass = CLASS_SYSTEM;
            default:    instrClass = CLASS_ILLEGAL;
        endcase
    end

    always_comb begin
        flowCtrl.jump = 1'b0;
        flowCtrl.branch = 1'b0;
        flowCtrl.pcSel = 1'b0;
        wbCtrl.regWrite = 1'b0;
        wbCtrl.memtoReg = 1'b1;
        wbCtrl.rdSrc = RD_ALU;
        case (instrClass)
            CLASS_R, CLASS_I: begin
                wbCtrl.regWrite = 1'b1;
            end
            CLASS_LOAD: begin
                wbCtrl.regWrite = 1'b1;
                wbCtrl.memtoReg = 1'b0;
            end
            CLASS_JALR: begin  // rd = pc + 4, pc = rs1 + imm
                flowCtrl.jump = 1'b1;
                flowCtrl.pcSel = 1'b1;
                wbCtrl.regWrite = 1'b1;
                wbCtrl.rdSrc = RD_PC4;
            end
            CLASS_STORE: begin
                wbCtrl.memtoReg = 1'b0;
            end
            CLASS_BRANCH: begin
                flowCtrl.branch = 1'b1;
            end
            CLASS_AUIPC: begin
                wbCtrl.regWrite = 1'b1;
                wbCtrl.rdSrc = RD_PCIMM;
            end
            CLASS_LUI: begin
                wbCtrl.regWrite = 1'b1;
                wbCtrl.rdSrc = RD_IMM;
            end
            CLASS_JAL: begin
                flowCtrl.jump = 1'b1;
                wbCtrl.regWrite = 1'b1;
                wbCtrl.rdSrc = RD_PC4;
            end
            CLASS_SYSTEM: begin
                // Only CSR accesses return a value to rd
                wbCtrl.regWrite = csrAccess;
                wbCtrl.rdSrc = csrAccess ? RD_CSR : RD_ALU;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- src/executeDecoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "control_config.svh"

module executeDecoder (
    input  var control_pkg::instrClass_e instrClass,
    input  var logic [2:0]               func3,
    input  var logic [6:0]               func7,
    input  var logic                     csrImmForm,
    output control_pkg::exCtrl_s         exCtrl
);
    import control_pkg::*;

    // OP and OP-IMM share this but only OP has multiplies and SUB
    function automatic aluOp_e arithOp(
        input logic [2:0] f3,
        input logic [6:0] f7,
        input logic       isReg
    );
        logic mulSel;
        logic subSel;
        mulSel = isReg & f7[0];
        subSel = isReg & f7[5];
        arithOp = ALU_ADD;
        case (f3)
            `F3_ADD:  arithOp = subSel ? ALU_SUB : (mulSel ? ALU_MUL : ALU_ADD);
            `F3_SLL:  arithOp = mulSel ? ALU_MULH : ALU_SLL;
            `F3_SLT:  arithOp = mulSel ? ALU_MULHSU : ALU_SLT;
            `F3_SLTU: arithOp = mulSel ? ALU_MULHU : ALU_SLTU;
            `F3_XOR:  arithOp = ALU_XOR;
            `F3_SR:   arithOp = f7[5] ? ALU_SRA : ALU_SRL;  // SRAI shares the bit
            `F3_OR:   arithOp = ALU_OR;
            `F3_AND:  arithOp = ALU_AND;
        endcase
        return arithOp;
    endfunction

    always_comb begin
        exCtrl.aluOp = ALU_ADD;
        exCtrl.aluSrc = 1'b0;
        exCtrl.immOp = IMM_NONE;
        case (instrClass)
            CLASS_R: begin
                exCtrl.aluOp = arithOp(func3, func7, 1'b1);
            end
            CLASS_I: begin
                exCtrl.aluOp = arithOp(func3, func7, 1'b0);
                exCtrl.aluSrc = 1'b1;
                exCtrl.immOp = (func3 == `F3_SLL || func3 == `F3_SR) ? IMM_ISHIFT : IMM_I;
            end
            CLASS_LOAD, CLASS_JALR: begin  // Address is rs1 + imm
                exCtrl.aluSrc = 1'b1;
                exCtrl.immOp = IMM_I;
            end
            CLASS_STORE: begin
                exCtrl.aluSrc = 1'b1;
                exCtrl.immOp = IMM_S;
            end
            CLASS_BRANCH: begin
                exCtrl.immOp = IMM_B;
                case (func3)
                    `F3_BEQ:  exCtrl.aluOp = ALU_BEQ;
                    `F3_BNE:  exCtrl.aluOp = ALU_BNE;
                    `F3_BLT:  exCtrl.aluOp = ALU_BLT;
                    `F3_BGE:  exCtrl.aluOp = ALU_BGE;
                    `F3_BLTU: exCtrl.aluOp = ALU_BLTU;
                    `F3_BGEU: exCtrl.aluOp = ALU_BGEU;
                    default:  exCtrl.aluOp = ALU_ADD;
                endcase
            end
            CLASS_AUIPC, CLASS_LUI: begin
                exCtrl.aluSrc = 1'b1;
                exCtrl.immOp = IMM_U;
            end
            CLASS_JAL: begin
                exCtrl.aluOp = ALU_JAL;
                exCtrl.aluSrc = 1'b1;
                exCtrl.immOp = IMM_J;
            end
            CLASS_SYSTEM: begin
                exCtrl.immOp = csrImmForm ? IMM_CSR : IMM_NONE;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- src/memAccessDecoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "control_config.svh"

module memAccessDecoder (
    input  var control_pkg::instrClass_e instrClass,
    input  var logic [2:0]               func3,
    output control_pkg::memCtrl_s        memCtrl
);
    import control_pkg::*;

    always_comb begin
        memCtrl.webN = 4'b1111;
        memCtrl.memRead = 1'b0;
        memCtrl.loadCon = LD_WORD;
        memCtrl.storeCon = ST_BYTE;
        case (instrClass)
            CLASS_LOAD: begin
                memCtrl.memRead = 1'b1;
                case (func3)  // Sign or zero extension
                    `F3_LB:  memCtrl.loadCon = LD_BYTE;
                    `F3_LH:  memCtrl.loadCon = LD_HALF;
                    `F3_LW:  memCtrl.loadCon = LD_WORD;
                    `F3_LHU: memCtrl.loadCon = LD_HALFU;
                    `F3_LBU: memCtrl.loadCon = LD_BYTEU;
                    default: memCtrl.loadCon = LD_WORD;
                endcase
            end
            CLASS_STORE: begin
                case (func3)
                    `F3_SH: begin
                        memCtrl.storeCon = ST_HALF;
                        memCtrl.webN = ~`STRB_HWORD;
                    end
                    `F3_SW: begin
                        memCtrl.storeCon = ST_WORD;
                        memCtrl.webN = ~`STRB_WORD;
                    end
                    default: begin  // SB and undefined widths
                        memCtrl.storeCon = ST_BYTE;
                        memCtrl.webN = ~`STRB_BYTE;
                    end
                endcase
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- src/systemDecoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "control_config.svh"

module systemDecoder (
    input  var control_pkg::instrClass_e instrClass,
    input  var logic [2:0]               func3,
    input  var logic [11:0]              funct12,
    output logic                         csrAccess,
    output control_pkg::csrCtrl_s        csrCtrl
);
    import control_pkg::*;

    always_comb begin
        csrAccess = 1'b0;
        csrCtrl.wfi = 1'b0;
        csrCtrl.csrReturn = 1'b0;
        csrCtrl.csrWrite = 1'b0;
        csrCtrl.csrAluSrc = 1'b0;
        csrCtrl.csrAluOp = CSR_DATA;
        if (instrClass == CLASS_SYSTEM) begin
            case (func3)
                `F3_PRIV: begin
                    csrCtrl.csrReturn = (funct12 == `F12_MRET);
                    csrCtrl.wfi = (funct12 == `F12_WFI);
                end
                `F3_CSRRW, `F3_CSRRS, `F3_CSRRC,
                `F3_CSRRWI, `F3_CSRRSI, `F3_CSRRCI: begin
                    csrAccess = 1'b1;
                    csrCtrl.csrWrite = 1'b1;
                    csrCtrl.csrAluSrc = func3[2];  // Immediate forms
                    case (func3[1:0])
                        2'd2:    csrCtrl.csrAluOp = CSR_OR;    // Set bits
                        2'd3:    csrCtrl.csrAluOp = CSR_ANDN;  // Clear bits
                        default: csrCtrl.csrAluOp = CSR_DATA;
                    endcase
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/control.sv
`timescale 1ns/1ps
`default_nettype none

module control (
    input  var control_pkg::instrWord_u instr,
    output control_pkg::exCtrl_s        exCtrl,
    output control_pkg::memCtrl_s       memCtrl,
    output control_pkg::wbCtrl_s        wbCtrl,
    output control_pkg::flowCtrl_s      flowCtrl,
    output control_pkg::csrCtrl_s       csrCtrl
);
    import control_pkg::*;

    instrClass_e instrClass;
    logic        csrAccess;

    mainDecoder uMainDecoder (
        .opcode    (instr.r.opcode),
        .csrAccess (csrAccess),
        .instrClass(instrClass),
        .wbCtrl    (wbCtrl),
        .flowCtrl  (flowCtrl)
    );

    executeDecoder uExecuteDecoder (
        .instrClass(instrClass),
        .func3     (instr.r.func3),
        .func7     (instr.r.func7),
        .csrImmForm(csrCtrl.csrAluSrc),  // CSRRxI takes zimm
        .exCtrl    (exCtrl)
    );

    memAccessDecoder uMemAccessDecoder (
        .instrClass(instrClass),
        .func3     (instr.r.func3),
        .memCtrl   (memCtrl)
    );

    systemDecoder uSystemDecoder (
        .instrClass(instrClass),
        .func3     (instr.r.func3),
        .funct12   (instr.sys.funct12),
        .csrAccess (csrAccess),
        .csrCtrl   (csrCtrl)
    );

endmodule

`default_nettype wire

//--- sim/controlTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "control_config.svh"

module controlTb;
    import control_pkg::*;

    typedef struct packed {
        exCtrl_s   ex;
        memCtrl_s  mem;
        wbCtrl_s   wb;
        flowCtrl_s flow;
        csrCtrl_s  csr;
    } ctrlAll_s;

    localparam int NUM_RANDOM = 2000;
    localparam int TIMEOUT_CYCLES = 2200;  // 8 reset + ~110 directed + random plus slack

    logic              clk = 1'b0;
    logic              arstN;
    instrWord_u        instr;
    exCtrl_s           exCtrl;
    memCtrl_s          memCtrl;
    wbCtrl_s           wbCtrl;
    flowCtrl_s         flowCtrl;
    csrCtrl_s          csrCtrl;
    ctrlAll_s          expCtrl;
    logic [31:0]       seed = 32'hd043c230;
    logic [`XLEN-1:0]  vecQ[$];
    int                cycles = 0;
    int                checkCount = 0;

    control dut (
        .instr   (instr),
        .exCtrl  (exCtrl),
        .memCtrl (memCtrl),
        .wbCtrl  (wbCtrl),
        .flowCtrl(flowCtrl),
        .csrCtrl (csrCtrl)
    );

    always #2 clk = ~clk;

    function automatic ctrlAll_s inactiveWord();
        ctrlAll_s c;
        c.ex.aluOp = ALU_ADD;
        c.ex.aluSrc = 1'b0;
        c.ex.immOp = IMM_NONE;
        c.mem.webN = 4'b1111;
        c.mem.memRead = 1'b0;
        c.mem.loadCon = LD_WORD;
        c.mem.storeCon = ST_BYTE;
        c.wb.regWrite = 1'b0;
        c.wb.memtoReg = 1'b1;
        c.wb.rdSrc = RD_ALU;
        c.flow = 3'b000;
        c.csr.wfi = 1'b0;
        c.csr.csrReturn = 1'b0;
        c.csr.csrWrite = 1'b0;
        c.csr.csrAluSrc = 1'b0;
        c.csr.csrAluOp = CSR_DATA;
        return c;
    endfunction

    function automatic ctrlAll_s refControl(input logic [`XLEN-1:0] w);
        logic [6:0]  op;
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic [11:0] f12;
        ctrlAll_s    c;
        op = w[6:0];
        f3 = w[14:12];
        f7 = w[31:25];
        f12 = w[31:20];
        c = inactiveWord();
        if (op == `OP_R || op == `OP_I) begin
            c.wb.regWrite = 1'b1;
            case (f3)
                3'd0: c.ex.aluOp = ALU_ADD;
                3'd1: c.ex.aluOp = ALU_SLL;
                3'd2: c.ex.aluOp = ALU_SLT;
                3'd3: c.ex.aluOp = ALU_SLTU;
                3'd4: c.ex.aluOp = ALU_XOR;
                3'd5: c.ex.aluOp = f7[5] ? ALU_SRA : ALU_SRL;
                3'd6: c.ex.aluOp = ALU_OR;
                default: c.ex.aluOp = ALU_AND;
            endcase
            if (op == `OP_I) begin
                c.ex.aluSrc = 1'b1;
                c.ex.immOp = (f3 == 3'd1 || f3 == 3'd5) ? IMM_ISHIFT : IMM_I;
            end else if (f3 == 3'd0 && f7[5]) begin
                c.ex.aluOp = ALU_SUB;
            end else if (f7[0] && f3 <= 3'd3) begin  // M extension
                case (f3)
                    3'd0: c.ex.aluOp = ALU_MUL;
                    3'd1: c.ex.aluOp = ALU_MULH;
                    3'd2: c.ex.aluOp = ALU_MULHSU;
                    default: c.ex.aluOp = ALU_MULHU;
                endcase
            end
        end
        case (op)
            `OP_LOAD: begin
                c.wb.regWrite = 1'b1;
                c.wb.memtoReg = 1'b0;
                c.ex.aluSrc = 1'b1;
                c.ex.immOp = IMM_I;
                c.mem.memRead = 1'b1;
                case (f3)
                    3'd0: c.mem.loadCon = LD_BYTE;
                    3'd1: c.mem.loadCon = LD_HALF;
                    3'd4: c.mem.loadCon = LD_BYTEU;
                    3'd5: c.mem.loadCon = LD_HALFU;
                    default: c.mem.loadCon = LD_WORD;
                endcase
            end
            `OP_STORE: begin
                c.wb.memtoReg = 1'b0;
                c.ex.aluSrc = 1'b1;
                c.ex.immOp = IMM_S;
                c.mem.storeCon = (f3 == 3'd1) ? ST_HALF : ((f3 == 3'd2) ? ST_WORD : ST_BYTE);
                c.mem.webN = (f3 == 3'd1) ? ~`STRB_HWORD
                           : ((f3 == 3'd2) ? ~`STRB_WORD : ~`STRB_BYTE);
            end
            `OP_BRANCH: begin
                c.flow.branch = 1'b1;
                c.ex.immOp = IMM_B;
                case (f3)
                    3'd0: c.ex.aluOp = ALU_BEQ;
                    3'd1: c.ex.aluOp = ALU_BNE;
                    3'd4: c.ex.aluOp = ALU_BLT;
                    3'd5: c.ex.aluOp = ALU_BGE;
                    3'd6: c.ex.aluOp = ALU_BLTU;
                    3'd7: c.ex.aluOp = ALU_BGEU;
                    default: c.ex.aluOp = ALU_ADD;
                endcase
            end
            `OP_JAL, `OP_JALR: begin
                c.flow.jump = 1'b1;
                c.flow.pcSel = (op == `OP_JALR);
                c.wb.regWrite = 1'b1;
                c.wb.rdSrc = RD_PC4;
                c.ex.aluSrc = 1'b1;
                c.ex.immOp = (op == `OP_JAL) ? IMM_J : IMM_I;
                c.ex.aluOp = (op == `OP_JAL) ? ALU_JAL : ALU_ADD;
            end
            `OP_AUIPC, `OP_LUI: begin
                c.wb.regWrite = 1'b1;
                c.wb.rdSrc = (op == `OP_LUI) ? RD_IMM : RD_PCIMM;
                c.ex.aluSrc = 1'b1;
                c.ex.immOp = IMM_U;
            end
            `OP_SYSTEM: begin
                if (f3 == 3'd0) begin
                    c.csr.csrReturn = (f12 == `F12_MRET);
                    c.csr.wfi = (f12 == `F12_WFI);
                end else if (f3 != 3'd4) begin  // CSR access
                    c.csr.csrWrite = 1'b1;
                    c.csr.csrAluSrc = f3[2];
                    c.csr.csrAluOp = (f3[1:0] == 2'd2) ? CSR_OR
                                   : ((f3[1:0] == 2'd3) ? CSR_ANDN : CSR_DATA);
                    c.wb.regWrite = 1'b1;
                    c.wb.rdSrc = RD_CSR;
                    c.ex.immOp = f3[2] ? IMM_CSR : IMM_NONE;
                end
            end
            default: begin
            end
        endcase
        return c;
    endfunction

    function automatic logic expectInactive(input logic [31:0] w);
        logic [6:0] op;
        op = w[6:0];
        if (op == `OP_SYSTEM) begin
            return (w[14:12] == 3'd4) ||
                   (w[14:12] == 3'd0 && w[31:20] != `F12_MRET && w[31:20] != `F12_WFI);
        end
        return !(op == `OP_R || op == `OP_I || op == `OP_LOAD || op == `OP_JALR ||
                 op == `OP_STORE || op == `OP_BRANCH || op == `OP_AUIPC ||
                 op == `OP_LUI || op == `OP_JAL);
    endfunction

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [6:0] pickOpcode(input logic [31:0] r);
        case (r % 32'd10)
            32'd0: return `OP_R;
            32'd1: return `OP_I;
            32'd2: return `OP_LOAD;
            32'd3: return `OP_JALR;
            32'd4: return `OP_STORE;
            32'd5: return `OP_BRANCH;
            32'd6: return `OP_AUIPC;
            32'd7: return `OP_LUI;
            32'd8: return `OP_JAL;
            default: return `OP_SYSTEM;
        endcase
    endfunction

    function automatic logic [31:0] encode(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [6:0] op);
        return {f7, 5'd7, 5'd9, f3, 5'd11, op};
    endfunction

    function automatic logic [31:0] encodeSys(input logic [11:0] f12, input logic [2:0] f3);
        return {f12, 5'd4, f3, 5'd5, `OP_SYSTEM};
    endfunction

    task automatic checkEq(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s: got %0h, expected %0h", $time, name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic buildDirected();
        logic [6:0] f7;
        for (int f = 0; f < 8; f++) begin
            for (int k = 0; k < 4; k++) begin
                f7 = {1'b0, k[1], 4'b0000, k[0]};  // func7 bits 5 and 0
                vecQ.push_back(encode(f7, f[2:0], `OP_R));
                vecQ.push_back(encode(f7, f[2:0], `OP_I));
            end
            vecQ.push_back(encode(7'h15, f[2:0], `OP_LOAD));
            vecQ.push_back(encode(7'h15, f[2:0], `OP_STORE));
            vecQ.push_back(encode(7'h15, f[2:0], `OP_BRANCH));
            vecQ.push_back(encodeSys(12'h300, f[2:0]));  // mstatus
        end
        vecQ.push_back(encode(7'h2a, 3'd5, `OP_JAL));
        vecQ.push_back(encode(7'h2a, 3'd0, `OP_JALR));
        vecQ.push_back(encode(7'h2a, 3'd5, `OP_AUIPC));
        vecQ.push_back(encode(7'h2a, 3'd5, `OP_LUI));
        vecQ.push_back(encodeSys(`F12_MRET, 3'd0));
        vecQ.push_back(encodeSys(`F12_WFI, 3'd0));
        vecQ.push_back(encodeSys(`F12_MRET, 3'd4));
        vecQ.push_back(encodeSys(`F12_WFI, 3'd4));
        vecQ.push_back(encodeSys(12'h000, 3'd0));  // ECALL
        vecQ.push_back(encode(7'h7f, 3'd7, 7'h00));
        vecQ.push_back(encode(7'h00, 3'd0, 7'h0f));  // FENCE is not decoded
        vecQ.push_back(encode(7'h01, 3'd0, 7'h3b));
        vecQ.push_back(encode(7'h55, 3'd2, 7'h7f));
    endtask

    task automatic applyWord(input logic [31:0] w);
        @(negedge clk);
        instr = w;
        arstN = 1'b1;
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("ERRORS FOUND");
            $fatal(1, "Timeout");
        end
    end

    always @(posedge clk) begin
        if (arstN) begin
            if (expectInactive(instr)) begin
                checkEq("inactive word", 64'({exCtrl, memCtrl, wbCtrl, flowCtrl, csrCtrl}),
                        64'(inactiveWord()));
            end
            expCtrl = refControl(instr);
            checkEq("exCtrl.aluOp", 64'(exCtrl.aluOp), 64'(expCtrl.ex.aluOp));
            checkEq("exCtrl.aluSrc", 64'(exCtrl.aluSrc), 64'(expCtrl.ex.aluSrc));
            checkEq("exCtrl.immOp", 64'(exCtrl.immOp), 64'(expCtrl.ex.immOp));
            checkEq("memCtrl.webN", 64'(memCtrl.webN), 64'(expCtrl.mem.webN));
            checkEq("memCtrl.memRead", 64'(memCtrl.memRead), 64'(expCtrl.mem.memRead));
            checkEq("memCtrl.loadCon", 64'(memCtrl.loadCon), 64'(expCtrl.mem.loadCon));
            checkEq("memCtrl.storeCon", 64'(memCtrl.storeCon), 64'(expCtrl.mem.storeCon));
            checkEq("wbCtrl.regWrite", 64'(wbCtrl.regWrite), 64'(expCtrl.wb.regWrite));
            checkEq("wbCtrl.memtoReg", 64'(wbCtrl.memtoReg), 64'(expCtrl.wb.memtoReg));
            checkEq("wbCtrl.rdSrc", 64'(wbCtrl.rdSrc), 64'(expCtrl.wb.rdSrc));
            checkEq("flowCtrl.jump", 64'(flowCtrl.jump), 64'(expCtrl.flow.jump));
            checkEq("flowCtrl.branch", 64'(flowCtrl.branch), 64'(expCtrl.flow.branch));
            checkEq("flowCtrl.pcSel", 64'(flowCtrl.pcSel), 64'(expCtrl.flow.pcSel));
            checkEq("csrCtrl.wfi", 64'(csrCtrl.wfi), 64'(expCtrl.csr.wfi));
            checkEq("csrCtrl.csrReturn", 64'(csrCtrl.csrReturn), 64'(expCtrl.csr.csrReturn));
            checkEq("csrCtrl.csrWrite", 64'(csrCtrl.csrWrite), 64'(expCtrl.csr.csrWrite));
            checkEq("csrCtrl.csrAluSrc", 64'(csrCtrl.csrAluSrc), 64'(expCtrl.csr.csrAluSrc));
            checkEq("csrCtrl.csrAluOp", 64'(csrCtrl.csrAluOp), 64'(expCtrl.csr.csrAluOp));
            checkCount++;
        end
    end

    initial begin
        logic [31:0] r1;
        logic [31:0] r2;
        arstN = 1'b0;
        instr = 32'h00000013;  // ADDI x0, x0, 0
        buildDirected();
        repeat (8) @(posedge clk);
        foreach (vecQ[i]) begin
            applyWord(vecQ[i]);
        end
        for (int n = 0; n < NUM_RANDOM; n++) begin
            seed = lcgNext(seed);
            r1 = seed;
            seed = lcgNext(seed);
            r2 = seed;
            if (r2[31:29] != 3'd7) begin  // Legal opcode 7 times in 8
                r1[6:0] = pickOpcode(32'(r2[28:3]));
            end
            applyWord(r1);
        end
        @(negedge clk);
        if (checkCount == vecQ.size() + NUM_RANDOM) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("Only %0d of %0d vectors were checked", checkCount,
                     vecQ.size() + NUM_RANDOM);
            $display("ERRORS FOUND");
            $fatal(1, "Vector count mismatch");
        end
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+include
src/control_pkg.sv
src/mainDecoder.sv
src/executeDecoder.sv
src/memAccessDecoder.sv
src/systemDecoder.sv
src/control.sv
sim/controlTb.sv

//--- run.sh
#!/bin/sh
# Build and run the decoder testbench with Verilator
verilator --binary --timing --timescale 1ns/1ps -f all.f \
    --top-module controlTb -o controlSim || { echo "Build failed"; exit 1; }
out=$(./obj_dir/controlSim)
echo "$out"
echo "$out" | grep -qx "NO ERRORS" && exit 0 || { echo "Simulation failed"; exit 1; }
